//--- common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [3:0]  lc3b_opcode;

    localparam lc3b_opcode op_br   = 4'b0000;
    localparam lc3b_opcode op_add  = 4'b0001;
    localparam lc3b_opcode op_ldb  = 4'b0010;
    localparam lc3b_opcode op_stb  = 4'b0011;
    localparam lc3b_opcode op_jsr  = 4'b0100;
    localparam lc3b_opcode op_and  = 4'b0101;
    localparam lc3b_opcode op_ldr  = 4'b0110;
    localparam lc3b_opcode op_str  = 4'b0111;
    localparam lc3b_opcode op_rsv  = 4'b1000; // RTI slot, not implemented.
    localparam lc3b_opcode op_not  = 4'b1001;
    localparam lc3b_opcode op_ldi  = 4'b1010;
    localparam lc3b_opcode op_sti  = 4'b1011;
    localparam lc3b_opcode op_jmp  = 4'b1100;
    localparam lc3b_opcode op_shf  = 4'b1101;
    localparam lc3b_opcode op_lea  = 4'b1110;
    localparam lc3b_opcode op_trap = 4'b1111;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_hold
    } fetch_state;

    // An all-zero control word is a bubble.
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_regfile;
        logic       load_cc;
        logic       mem_read;
        logic       mem_write;
        logic       use_imm;
        logic       is_branch;
        logic       is_jump;
        logic       is_trap;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_word         pc;
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_reg          src1;
        lc3b_reg          src2;
        lc3b_word         imm5;
        lc3b_word         imm4;
        lc3b_word         trapvect8;
        lc3b_word         offset6;
        lc3b_word         offset9;
        lc3b_word         offset11;
    } lc3b_id_bundle;

endpackage : lc3b_pkg

`default_nettype wire

//--- decode/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode
    import lc3b_pkg::*;
(
    input  wire lc3b_word    instr,
    output lc3b_control_word ctrl_word,
    output lc3b_word         offset6,
    output lc3b_word         offset9,
    output lc3b_word         offset11
);

    lc3b_opcode opcode;

    assign opcode = instr[15:12];

    // Offsets are word counts, so each is doubled into a byte offset.
    assign offset6  = {{9{instr[5]}}, instr[5:0], 1'b0};
    assign offset9  = {{6{instr[8]}}, instr[8:0], 1'b0};
    assign offset11 = {{4{instr[10]}}, instr[10:0], 1'b0};

    always_comb
    begin
        ctrl_word        = '0;
        ctrl_word.opcode = opcode;

        case (opcode)
            op_add, op_and:
            begin
                ctrl_word.aluop        = (opcode == op_add) ? alu_add : alu_and;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.load_cc      = 1'b1;
                ctrl_word.use_imm      = instr[5];
            end
            op_not:
            begin
                ctrl_word.aluop        = alu_not;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.load_cc      = 1'b1;
            end
            op_shf:
            begin
                // Bit 4 picks the direction and bit 5 the kind of right shift.
                if (!instr[4])
                    ctrl_word.aluop = alu_sll;
                else if (instr[5])
                    ctrl_word.aluop = alu_sra;
                else
                    ctrl_word.aluop = alu_srl;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.load_cc      = 1'b1;
            end
            op_ldr, op_ldb, op_ldi:
            begin
                ctrl_word.aluop        = alu_add; // Base plus offset.
                ctrl_word.mem_read     = 1'b1;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.load_cc      = 1'b1;
            end
            op_str, op_stb, op_sti:
            begin
                ctrl_word.aluop     = alu_add;
                ctrl_word.mem_write = 1'b1;
            end
            op_br:
            begin
                ctrl_word.is_branch = 1'b1;
            end
            op_jmp:
            begin
                ctrl_word.is_jump = 1'b1;
            end
            op_jsr:
            begin
                ctrl_word.is_jump      = 1'b1;
                ctrl_word.load_regfile = 1'b1; // Return address goes to R7.
            end
            op_trap:
            begin
                ctrl_word.is_trap      = 1'b1;
                ctrl_word.load_regfile = 1'b1;
            end
            op_lea:
            begin
                ctrl_word.aluop        = alu_pass;
                ctrl_word.load_regfile = 1'b1;
            end
            op_rsv:
            begin
                ctrl_word = '0;
            end
        endcase
    end

endmodule : instr_decode

`default_nettype wire

//--- dv/imem_model.sv
`timescale 1ns/1ns
`default_nettype none

module imem_model
    import lc3b_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h0000_0001
)
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     cyc,
    input  wire logic     stb,
    input  wire logic     we,
    input  wire lc3b_word adr,
    output lc3b_word      dat,
    output logic          ack
);

    integer      seed = SEED;
    logic [31:0] draw;
    logic        busy;
    logic [1:0]  cnt;

    // Program covers every opcode, a zero word and the reserved opcode.
    function automatic lc3b_word mem_word(input lc3b_word a);
        case (a)
            16'h0000: mem_word = 16'h0000;
            16'h0002: mem_word = 16'h1234;
            16'h0004: mem_word = 16'h5A7F;
            16'h0006: mem_word = 16'h9EBF;
            16'h0008: mem_word = 16'hD202;
            16'h000A: mem_word = 16'hD211;
            16'h000C: mem_word = 16'hD231;
            16'h000E: mem_word = 16'h6A86;
            16'h0010: mem_word = 16'h2345;
            16'h0012: mem_word = 16'hA123;
            16'h0014: mem_word = 16'h7456;
            16'h0016: mem_word = 16'h3210;
            16'h0018: mem_word = 16'hB0F0;
            16'h001A: mem_word = 16'h0E05;
            16'h001C: mem_word = 16'hC1C0;
            16'h001E: mem_word = 16'h4801;
            16'h0020: mem_word = 16'hF025;
            16'h0022: mem_word = 16'hE3FE;
            16'h0024: mem_word = 16'h8000;
            16'h0026: mem_word = 16'h8ABC;
            16'h0028: mem_word = 16'h1A3F;
            16'h002A: mem_word = 16'h0000;
            16'h002C: mem_word = 16'h5005;
            16'h002E: mem_word = 16'h0FFF;
            default:  mem_word = {a[7:0] ^ a[15:8], a[15:8] ^ 8'h3C};
        endcase
    endfunction

    assign dat = ack ? mem_word(adr) : 16'h0000;

    // Each bus cycle waits 0 to 3 extra cycles before ack.
    always @(posedge clk)
    begin
        if (rst)
        begin
            ack  <= 1'b0;
            busy <= 1'b0;
            cnt  <= 2'd0;
        end
        else
        begin
            ack <= 1'b0;
            if (cyc && stb && !we && !ack)
            begin
                if (!busy)
                begin
                    draw = $random(seed);
                    if (draw[1:0] == 2'd0)
                        ack <= 1'b1;
                    else
                    begin
                        busy <= 1'b1;
                        cnt  <= draw[1:0] - 2'd1;
                    end
                end
                else if (cnt == 2'd0)
                begin
                    ack  <= 1'b1;
                    busy <= 1'b0;
                end
                else
                    cnt <= cnt - 2'd1;
            end
        end
    end

endmodule : imem_model

`default_nettype wire

//--- dv/tb_lc3b_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_frontend
    import lc3b_pkg::*;
;

    localparam lc3b_word RESET_PC = 16'h0000;

    logic          clk;
    logic          rst;
    logic          stall;
    logic          redirect;
    lc3b_word      redirect_pc;
    lc3b_word      wb_dat_in;
    logic          wb_ack;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    lc3b_word      wb_adr;
    lc3b_id_bundle id_bundle;

    lc3b_word      adr_q[$];
    lc3b_word      dat_q[$];
    lc3b_word      expect_adr;
    lc3b_id_bundle last_bundle;
    logic          drop_next;
    logic          hold_check;
    logic          armed;
    int            bundles_seen;
    int            checks;
    int            errors;
    int            tests;

    lc3b_frontend #(
        .RESET_PC(RESET_PC)
    ) lc3b_frontend_inst (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .wb_dat_in  (wb_dat_in),
        .wb_ack     (wb_ack),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .id_bundle  (id_bundle)
    );

    imem_model #(
        .SEED(32'he3902dd8)
    ) imem_inst (
        .clk(clk),
        .rst(rst),
        .cyc(wb_cyc),
        .stb(wb_stb),
        .we (wb_we),
        .adr(wb_adr),
        .dat(wb_dat_in),
        .ack(wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic lc3b_control_word expect_ctrl(input lc3b_word w);
        lc3b_control_word c;
        c        = '0;
        c.opcode = w[15:12];
        case (w[15:12])
            4'h1, 4'h5:
            begin
                c.aluop        = (w[15:12] == 4'h1) ? alu_add : alu_and;
                c.load_regfile = 1'b1;
                c.load_cc      = 1'b1;
                c.use_imm      = w[5];
            end
            4'h9:
            begin
                c.aluop        = alu_not;
                c.load_regfile = 1'b1;
                c.load_cc      = 1'b1;
            end
            4'hD:
            begin
                c.aluop        = !w[4] ? alu_sll : (w[5] ? alu_sra : alu_srl);
                c.load_regfile = 1'b1;
                c.load_cc      = 1'b1;
            end
            4'h6, 4'h2, 4'hA:
            begin
                c.aluop        = alu_add;
                c.mem_read     = 1'b1;
                c.load_regfile = 1'b1;
                c.load_cc      = 1'b1;
            end
            4'h7, 4'h3, 4'hB:
            begin
                c.aluop     = alu_add;
                c.mem_write = 1'b1;
            end
            4'h0: c.is_branch = 1'b1;
            4'hC: c.is_jump = 1'b1;
            4'h4:
            begin
                c.is_jump      = 1'b1;
                c.load_regfile = 1'b1;
            end
            4'hF:
            begin
                c.is_trap      = 1'b1;
                c.load_regfile = 1'b1;
            end
            4'hE:
            begin
                c.aluop        = alu_pass;
                c.load_regfile = 1'b1;
            end
            default: c = '0;
        endcase
        if (w == 16'h0000)
            c = '0; // A zero word is a bubble.
        expect_ctrl = c;
    endfunction

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
        checks++;
        assert (exp === act)
        else
        begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic note_error(input string what);
        errors++;
        $display("ERROR: %s at %0t ns", what, $time);
    endtask

    task automatic check_bundle(input lc3b_word a, input lc3b_word w);
        lc3b_control_word c;
        c = expect_ctrl(w);
        check_word("id_bundle.pc", a + 16'd2, id_bundle.pc);
        check_word("id_bundle.ctrl", {1'b0, c}, {1'b0, id_bundle.ctrl});
        check_word("id_bundle.dest", {13'd0, w[11:9]}, {13'd0, id_bundle.dest});
        check_word("id_bundle.src1", {13'd0, w[8:6]}, {13'd0, id_bundle.src1});
        check_word("id_bundle.src2", {13'd0, w[2:0]}, {13'd0, id_bundle.src2});
        check_word("id_bundle.imm5", {{11{w[4]}}, w[4:0]}, id_bundle.imm5);
        check_word("id_bundle.imm4", {12'd0, w[3:0]}, id_bundle.imm4);
        check_word("id_bundle.trapvect8", {7'd0, w[7:0], 1'b0}, id_bundle.trapvect8);
        check_word("id_bundle.offset6", {{9{w[5]}}, w[5:0], 1'b0}, id_bundle.offset6);
        check_word("id_bundle.offset9", {{6{w[8]}}, w[8:0], 1'b0}, id_bundle.offset9);
        check_word("id_bundle.offset11", {{4{w[10]}}, w[10:0], 1'b0}, id_bundle.offset11);
    endtask

    // Scoreboard of ack'd fetches matched against bundles leaving IF/ID.
    always @(posedge clk)
    begin
        if (rst)
        begin
            adr_q.delete();
            dat_q.delete();
            expect_adr  = RESET_PC;
            drop_next   = 1'b0;
            last_bundle = '0;
        end
        else
        begin
            if (id_bundle.valid && (!last_bundle.valid || id_bundle.pc != last_bundle.pc))
            begin
                bundles_seen++;
                if (adr_q.size() == 0)
                    note_error("a bundle left IF/ID with no fetch behind it");
                else
                    check_bundle(adr_q.pop_front(), dat_q.pop_front());
            end
            last_bundle = id_bundle;
            if (wb_cyc && wb_ack)
            begin
                if (redirect || drop_next)
                    drop_next = 1'b0; // Data of the abandoned path.
                else
                begin
                    check_word("wb_adr", expect_adr, wb_adr);
                    adr_q.push_back(wb_adr);
                    dat_q.push_back(wb_dat_in);
                    expect_adr = expect_adr + 16'd2;
                end
            end
            else if (redirect && wb_cyc)
                drop_next = 1'b1;
            if (redirect)
            begin
                adr_q.delete();
                dat_q.delete();
                expect_adr = redirect_pc;
            end
        end
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else note_error("stb was high without cyc");

    adr_holds: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else note_error("wb_adr changed while waiting for ack");

    never_writes: assert property (@(posedge clk) disable iff (rst) !wb_we)
        else note_error("wb_we was high on the instruction port");

    quiet_after_reset: assert property (@(posedge clk) disable iff (!armed)
        $past(rst) |-> !wb_cyc && !wb_stb && !id_bundle.valid)
        else note_error("bus or bundle active during or just after reset");

    stall_freezes: assert property (@(posedge clk) disable iff (rst)
        stall && !redirect |=> $stable(id_bundle))
        else note_error("id_bundle changed under stall");

    redirect_kills: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !id_bundle.valid)
        else note_error("bundle still valid after redirect");

    no_fetch_held: assert property (@(posedge clk) disable iff (rst) hold_check |-> !wb_stb)
        else note_error("a new bus cycle started while stalled with a full buffer");

    task automatic give_up(input string what);
        $display("ERROR: timed out waiting for %s", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_bundles(input int n, input string what);
        int target;
        int guard;
        target = bundles_seen + n;
        guard  = 0;
        while (bundles_seen < target)
        begin
            @(posedge clk);
            #1;
            guard++;
            if (guard > 500)
                give_up(what);
        end
    endtask

    task automatic wait_bus_busy();
        int guard;
        guard = 0;
        while (!(wb_stb && !wb_ack))
        begin
            @(posedge clk);
            #1;
            guard++;
            if (guard > 50)
                give_up("a bus cycle in progress");
        end
    endtask

    task automatic wait_bus_idle();
        int guard;
        int quiet;
        guard = 0;
        quiet = 0;
        while (quiet < 2)
        begin
            @(posedge clk);
            #1;
            quiet = wb_cyc ? 0 : quiet + 1;
            guard++;
            if (guard > 50)
                give_up("the bus to go idle");
        end
    endtask

    // Holds redirect for the current cycle only.
    task automatic pulse_redirect(input lc3b_word target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial
    begin
        armed = 1'b0;
        repeat (2) @(posedge clk);
        armed = 1'b1;
    end

    initial
    begin
        rst          = 1'b1;
        stall        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = 16'h0000;
        hold_check   = 1'b0;
        bundles_seen = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        wait_bundles(1, "the first bundle");
        report_test("reset");

        wait_bundles(30, "the program bundles");
        report_test("straight_line");

        stall = 1'b1;
        wait_bus_idle();
        hold_check = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        hold_check = 1'b0;
        stall      = 1'b0;
        wait_bundles(4, "bundles after stall release");
        report_test("stall");

        wait_bus_busy();
        pulse_redirect(16'h0080);
        wait_bundles(6, "bundles after redirect");
        report_test("redirect_busy");

        stall = 1'b1;
        wait_bus_idle();
        pulse_redirect(16'h0010);
        stall = 1'b0;
        wait_bundles(5, "bundles after redirect under stall");
        report_test("redirect_stalled");

        repeat (3) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule : tb_lc3b_frontend

`default_nettype wire

//--- fetch/if_stage.sv
`timescale 1ns/1ns
`default_nettype none

module if_stage
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     redirect,
    input  wire lc3b_word redirect_pc,
    input  wire lc3b_word wb_dat_in,
    input  wire logic     wb_ack,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output lc3b_word      wb_adr,
    output lc3b_word      fetched_instr,
    output lc3b_word      fetched_pc,
    output logic          fetched_valid,
    output logic          advance
);

    fetch_state state;
    lc3b_word   pc;
    lc3b_word   instr_buf;
    lc3b_word   fetch_target;
    logic       drop_pending;
    logic       discard;
    logic       start_bus;
    logic       take_data;

    assign wb_cyc = (state == st_bus);
    assign wb_stb = (state == st_bus);
    assign wb_we  = 1'b0; // Instruction port never writes.

    assign fetched_valid = (state == st_hold);
    assign fetched_instr = instr_buf;
    assign fetched_pc    = pc; // PC always names the instruction in flight or held.

    assign advance = fetched_valid && !stall && !redirect;

    // Data of a cycle that was overtaken by a redirect is thrown away.
    assign discard   = drop_pending || redirect;
    assign take_data = (state == st_bus) && wb_ack && !discard;

    // A new bus cycle begins from idle, or from hold once the buffer is released.
    assign start_bus = (state == st_idle) ||
                       ((state == st_hold) && (advance || redirect));

    always_comb
    begin
        if (redirect)
            fetch_target = redirect_pc;
        else if (advance)
            fetch_target = pc + 16'd2;
        else
            fetch_target = pc;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= st_idle;
            pc           <= RESET_PC;
            drop_pending <= 1'b0;
        end
        else
        begin
            if (redirect || advance)
                pc <= fetch_target;

            case (state)
                st_idle:
                begin
                    state <= st_bus;
                end
                st_bus:
                begin
                    if (wb_ack)
                    begin
                        drop_pending <= 1'b0;
                        state        <= discard ? st_idle : st_hold; // Cyc drops after ack.
                    end
                    else if (redirect)
                    begin
                        drop_pending <= 1'b1; // Cycle cannot be aborted, so mark it stale.
                    end
                end
                st_hold:
                begin
                    if (advance || redirect)
                        state <= st_bus;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_bus)
            wb_adr <= fetch_target;
        if (take_data)
            instr_buf <= wb_dat_in;
    end

    adr_stable: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr));

    // A stalled buffer keeps its instruction until released or redirected.
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        fetched_valid && stall && !redirect |=> fetched_valid && $stable(fetched_pc));

endmodule : if_stage

`default_nettype wire

//--- fetch/ifid.sv
`timescale 1ns/1ns
`default_nettype none

module ifid
    import lc3b_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             advance,
    input  wire logic             flush,
    input  wire lc3b_word         instr,
    input  wire lc3b_word         pc_in,
    input  wire lc3b_control_word ctrl_word_in,
    input  wire lc3b_word         offset6_in,
    input  wire lc3b_word         offset9_in,
    input  wire lc3b_word         offset11_in,
    output lc3b_id_bundle         id
);

    lc3b_id_bundle next_id;
    logic          is_nop;

    assign is_nop = (instr == 16'h0000);

    always_comb
    begin
        next_id = '0;

        next_id.valid = 1'b1;
        next_id.pc    = pc_in + 16'd2;

        // BR with no condition bits and a zero offset is treated as a bubble.
        if (is_nop)
            next_id.ctrl = '0;
        else
            next_id.ctrl = ctrl_word_in;

        next_id.dest = instr[11:9];
        next_id.src1 = instr[8:6];
        next_id.src2 = instr[2:0];

        next_id.imm5      = {{11{instr[4]}}, instr[4:0]};
        next_id.imm4      = {12'd0, instr[3:0]};
        next_id.trapvect8 = {7'd0, instr[7:0], 1'b0}; // Byte address of the vector entry.

        next_id.offset6  = offset6_in;
        next_id.offset9  = offset9_in;
        next_id.offset11 = offset11_in;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            id <= '0;
        end
        else if (advance)
        begin
            id <= next_id;
        end
    end

    flush_kills_bundle: assert property (@(posedge clk)
        flush |=> !id.valid);

endmodule : ifid

`default_nettype wire

//--- rtl/lc3b_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_frontend
    import lc3b_pkg::*;
#(
    parameter lc3b_word RESET_PC = 16'h0000
)
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     redirect,
    input  wire lc3b_word redirect_pc,
    input  wire lc3b_word wb_dat_in,
    input  wire logic     wb_ack,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output lc3b_word      wb_adr,
    output lc3b_id_bundle id_bundle
);

    lc3b_word         fetched_instr;
    lc3b_word         fetched_pc;
    logic             fetched_valid;
    logic             advance;
    lc3b_control_word ctrl_word;
    lc3b_word         offset6;
    lc3b_word         offset9;
    lc3b_word         offset11;

    if_stage #(
        .RESET_PC(RESET_PC)
    ) if_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .wb_dat_in    (wb_dat_in),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .fetched_instr(fetched_instr),
        .fetched_pc   (fetched_pc),
        .fetched_valid(fetched_valid),
        .advance      (advance)
    );

    instr_decode instr_decode_inst (
        .instr    (fetched_instr),
        .ctrl_word(ctrl_word),
        .offset6  (offset6),
        .offset9  (offset9),
        .offset11 (offset11)
    );

    ifid ifid_inst (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .flush       (redirect), // A redirect squashes whatever sits in IF/ID.
        .instr       (fetched_instr),
        .pc_in       (fetched_pc),
        .ctrl_word_in(ctrl_word),
        .offset6_in  (offset6),
        .offset9_in  (offset9),
        .offset11_in (offset11),
        .id          (id_bundle)
    );

    // A buffered instruction that is free to move appears in IF/ID one edge later.
    bundle_follows_fetch: assert property (@(posedge clk) disable iff (rst)
        fetched_valid && !stall && !redirect
            |=> id_bundle.valid && (id_bundle.pc == $past(fetched_pc) + 16'd2));

endmodule : lc3b_frontend

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_lc3b_frontend \
    -f sim.f \
    -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log

cat sim.log

! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log && exit 0 || exit 1

//--- sim.f
common/lc3b_pkg.sv
fetch/if_stage.sv
fetch/ifid.sv
decode/instr_decode.sv
rtl/lc3b_frontend.sv
dv/imem_model.sv
dv/tb_lc3b_frontend.sv
